// ==== ghost_chase_input.txt ====
// columns: gap pac_x pac_y exp_x exp_y in hex
// a zero gap keeps move_valid high through the busy cycle of the move before
01 0e 02 03 02
00 0e 02 04 02
00 0e 02 05 02
02 0e 02 06 02
01 07 0a 07 02
00 07 00 07 01
03 07 00 06 01
00 06 00 05 01
01 05 01 04 01
00 04 01 03 01
00 03 01 02 01
02 02 01 01 01
01 01 01 01 02
00 01 05 01 03
01 0a 04 02 03
00 0a 04 02 04
02 0a 04 03 04
00 06 07 03 05
01 06 07 04 05
00 06 07 04 06
00 06 07 05 06
01 06 07 05 07
00 08 06 06 07
02 06 04 07 07

// ==== ghost_chase.f ====
+incdir+.
maze_pkg.sv
ghost_pkg.sv
maze_map.sv
chase_arbiter.sv
ghost_mover.sv
ghost_chase.sv
ghost_chase_props.sv
ghost_chase_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the ghost chase testbench with verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -j 0 \
    --top-module ghost_chase_tb -f ghost_chase.f -o sim_ghost_chase
./obj_dir/sim_ghost_chase > sim.log 2>&1 || true
cat sim.log
if grep -q '^\*\* PASS \*\*$' sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

// ==== ghost_chase_tb.sv ====
`include "ghost_chase_defines.svh"

module ghost_chase_tb;

    import maze_pkg::*;

    localparam int NUM_REQ = 24;
    // gap, pac_x, pac_y, exp_x, exp_y
    localparam int FIELDS  = 5;

    logic        clk;
    logic        rst;
    logic        move_valid;
    logic        move_ready;
    tile_coord_t pac_x;
    tile_coord_t pac_y;
    tile_coord_t ghost_x;
    tile_coord_t ghost_y;
    pixel_t      box_left;
    pixel_t      box_top;
    pixel_t      box_right;
    pixel_t      box_bottom;
    logic        pos_valid;

    logic [7:0]  stim [0:NUM_REQ*FIELDS-1];
    logic [31:0] rng_state;
    int          errors  = 0;
    int          checks  = 0;
    int          strobes = 0;

    ghost_chase dut (
        .clk        (clk),
        .rst        (rst),
        .move_valid (move_valid),
        .move_ready (move_ready),
        .pac_x      (pac_x),
        .pac_y      (pac_y),
        .ghost_x    (ghost_x),
        .ghost_y    (ghost_y),
        .box_left   (box_left),
        .box_top    (box_top),
        .box_right  (box_right),
        .box_bottom (box_bottom),
        .pos_valid  (pos_valid)
    );

    bind ghost_mover ghost_chase_props u_props (
        .clk        (clk),
        .rst        (rst),
        .move_valid (move_valid),
        .move_ready (move_ready),
        .pos_valid  (pos_valid),
        .ghost_x    (ghost_x),
        .ghost_y    (ghost_y)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // count every result strobe for the final tally against the requests
    always @(negedge clk) begin
        if (!rst && pos_valid) begin
            strobes <= strobes + 1;
        end
    end

    ////////////////////
    // helpers
    ////////////////////

    function automatic logic [31:0] xorshift(logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // tile t spans TILE_PX*(t-1) to TILE_PX*t on each axis
    function automatic pixel_t edge_low(tile_coord_t t);
        return pixel_t'(`TILE_PX * (int'(t) - 1));
    endfunction

    function automatic pixel_t edge_high(tile_coord_t t);
        return pixel_t'(`TILE_PX * int'(t));
    endfunction

    task automatic check_tile(input string name, input tile_coord_t got, input tile_coord_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_pixel(input string name, input pixel_t got, input pixel_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_position(input tile_coord_t ex, input tile_coord_t ey);
        check_tile("ghost_x", ghost_x, ex);
        check_tile("ghost_y", ghost_y, ey);
        check_pixel("box_left", box_left, edge_low(ex));
        check_pixel("box_right", box_right, edge_high(ex));
        check_pixel("box_top", box_top, edge_low(ey));
        check_pixel("box_bottom", box_bottom, edge_high(ey));
    endtask

    // both waits start on a falling edge and look at the current value first
    task automatic wait_ready(output logic ok);
        int n;
        n = 0;
        while (move_ready !== 1'b1 && n < 20) begin
            @(negedge clk);
            n++;
        end
        ok = (move_ready === 1'b1);
    endtask

    task automatic wait_pos_valid(output logic ok);
        int n;
        n = 0;
        while (pos_valid !== 1'b1 && n < 20) begin
            @(negedge clk);
            n++;
        end
        ok = (pos_valid === 1'b1);
    endtask

    // idle for the file gap plus a random extra, then raise the request
    task automatic issue_request(input int k);
        int gap;
        int extra;
        gap   = int'(stim[k*FIELDS]);
        extra = 0;
        if (gap != 0) begin
            rng_state = xorshift(rng_state);
            extra     = int'(rng_state % 32'd3);
        end
        repeat (gap + extra) @(posedge clk);
        @(posedge clk);
        move_valid <= 1'b1;
        pac_x      <= tile_coord_t'(stim[k*FIELDS+1]);
        pac_y      <= tile_coord_t'(stim[k*FIELDS+2]);
        @(negedge clk);
    endtask

    ////////////////////
    // main sequence
    ////////////////////

    initial begin
        logic        ok;
        int          err_before;
        int          done_reqs;
        tile_coord_t ex;
        tile_coord_t ey;
        rst        = 1'b1;
        move_valid = 1'b0;
        pac_x      = '0;
        pac_y      = '0;
        rng_state  = 32'h4de8988c;
        done_reqs  = 0;
        ok         = 1'b1;
        $readmemh("ghost_chase_input.txt", stim);
        // a loaded last field is an expected row and never the border row 0
        if ($isunknown(stim[NUM_REQ*FIELDS-1]) || (stim[NUM_REQ*FIELDS-1] == 8'h00)) begin
            $display("stimulus file is missing or has fewer than %0d requests", NUM_REQ);
            errors++;
            ok = 1'b0;
        end
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        // start tile, idle handshake
        err_before = errors;
        check_position(tile_coord_t'(`START_X), tile_coord_t'(`START_Y));
        check_flag("move_ready", move_ready, 1'b1);
        check_flag("pos_valid", pos_valid, 1'b0);
        $display("reset state %s", (errors == err_before) ? "ok" : "mismatch");
        if (ok) begin
            issue_request(0);
        end
        for (int i = 0; i < NUM_REQ && ok; i++) begin
            err_before = errors;
            ex = tile_coord_t'(stim[i*FIELDS+3]);
            ey = tile_coord_t'(stim[i*FIELDS+4]);
            wait_ready(ok);
            if (!ok) begin
                $display("request %0d timed out waiting for move_ready", i);
                errors++;
            end else begin
                @(posedge clk);
                // zero gap holds move_valid with the next tile while busy
                if (i + 1 < NUM_REQ && stim[(i+1)*FIELDS] == 8'h00) begin
                    pac_x <= tile_coord_t'(stim[(i+1)*FIELDS+1]);
                    pac_y <= tile_coord_t'(stim[(i+1)*FIELDS+2]);
                end else begin
                    move_valid <= 1'b0;
                end
                @(negedge clk);
                wait_pos_valid(ok);
                if (!ok) begin
                    $display("request %0d timed out waiting for pos_valid", i);
                    errors++;
                end else begin
                    check_position(ex, ey);
                    done_reqs++;
                    $display("request %0d pac (%0d,%0d) ghost (%0d,%0d) %s", i,
                             stim[i*FIELDS+1], stim[i*FIELDS+2], ghost_x, ghost_y,
                             (errors == err_before) ? "ok" : "mismatch");
                    if (i + 1 < NUM_REQ && stim[(i+1)*FIELDS] != 8'h00) begin
                        issue_request(i + 1);
                    end
                end
            end
        end
        // room for a stray extra strobe to show up
        repeat (3) @(negedge clk);
        if (strobes != done_reqs) begin
            $display("pos_valid strobed %0d times for %0d requests", strobes, done_reqs);
            errors++;
        end
        // properties of the bound checker
        if (dut.u_mover.u_props.fail_count != 0) begin
            $display("bound assertions failed %0d times", dut.u_mover.u_props.fail_count);
            errors += dut.u_mover.u_props.fail_count;
        end
        $display("requests %0d of %0d checks %0d errors %0d", done_reqs, NUM_REQ,
                 checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// ==== ghost_chase_props.sv ====
`include "ghost_chase_defines.svh"

module ghost_chase_props (
    input logic                  clk,
    input logic                  rst,
    input logic                  move_valid,
    input logic                  move_ready,
    input logic                  pos_valid,
    input maze_pkg::tile_coord_t ghost_x,
    input maze_pkg::tile_coord_t ghost_y
);

    import maze_pkg::*;

    logic on_wall;

    // number of property failures so far
    int fail_count = 0;

    // border ring or a pillar where both coordinates are multiples of the step
    assign on_wall = (ghost_x == '0) || (ghost_y == '0) ||
                     (ghost_x >= tile_coord_t'(`MAZE_W - 1)) ||
                     (ghost_y >= tile_coord_t'(`MAZE_H - 1)) ||
                     (((ghost_x % tile_coord_t'(`PILLAR_STEP)) == '0) &&
                      ((ghost_y % tile_coord_t'(`PILLAR_STEP)) == '0));

    ////////////////////
    // handshake
    ////////////////////

    // result strobe lasts one cycle
    pos_valid_single: assert property (
        @(posedge clk) disable iff (rst) pos_valid |=> !pos_valid
    ) else begin
        fail_count++;
        $error("pos_valid high on two cycles in a row");
    end

    // busy for the step cycle after an accept
    ready_drops_after_accept: assert property (
        @(posedge clk) disable iff (rst) (move_valid && move_ready) |=> !move_ready
    ) else begin
        fail_count++;
        $error("move_ready still high in the cycle after an accept");
    end

    ////////////////////
    // position
    ////////////////////

    ghost_off_walls: assert property (
        @(posedge clk) disable iff (rst) !on_wall
    ) else begin
        fail_count++;
        $error("ghost tile lies on a wall");
    end

endmodule

// ==== ghost_chase.sv ====
module ghost_chase (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  move_valid,
    output logic                  move_ready,
    input  maze_pkg::tile_coord_t pac_x,
    input  maze_pkg::tile_coord_t pac_y,
    output maze_pkg::tile_coord_t ghost_x,
    output maze_pkg::tile_coord_t ghost_y,
    output maze_pkg::pixel_t      box_left,
    output maze_pkg::pixel_t      box_top,
    output maze_pkg::pixel_t      box_right,
    output maze_pkg::pixel_t      box_bottom,
    output logic                  pos_valid
);

    import maze_pkg::*;
    import ghost_pkg::*;

    // open neighbours of the current tile
    dir_mask_t   open_dirs;
    // registered heading and the arbiter's pick
    heading_e    heading;
    heading_e    next_heading;
    // player tile latched at accept
    tile_coord_t target_x;
    tile_coord_t target_y;

    maze_map u_map (
        .tile_x    (ghost_x),
        .tile_y    (ghost_y),
        .open_dirs (open_dirs)
    );

    chase_arbiter u_arbiter (
        .ghost_x      (ghost_x),
        .ghost_y      (ghost_y),
        .pac_x        (target_x),
        .pac_y        (target_y),
        .open_dirs    (open_dirs),
        .heading      (heading),
        .next_heading (next_heading)
    );

    ghost_mover u_mover (
        .clk          (clk),
        .rst          (rst),
        .move_valid   (move_valid),
        .pac_x        (pac_x),
        .pac_y        (pac_y),
        .next_heading (next_heading),
        .move_ready   (move_ready),
        .pos_valid    (pos_valid),
        .ghost_x      (ghost_x),
        .ghost_y      (ghost_y),
        .heading      (heading),
        .target_x     (target_x),
        .target_y     (target_y),
        .box_left     (box_left),
        .box_top      (box_top),
        .box_right    (box_right),
        .box_bottom   (box_bottom)
    );

endmodule

// ==== ghost_mover.sv ====
`include "ghost_chase_defines.svh"

module ghost_mover (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  move_valid,
    input  maze_pkg::tile_coord_t pac_x,
    input  maze_pkg::tile_coord_t pac_y,
    input  ghost_pkg::heading_e   next_heading,
    output logic                  move_ready,
    output logic                  pos_valid,
    output maze_pkg::tile_coord_t ghost_x,
    output maze_pkg::tile_coord_t ghost_y,
    output ghost_pkg::heading_e   heading,
    output maze_pkg::tile_coord_t target_x,
    output maze_pkg::tile_coord_t target_y,
    output maze_pkg::pixel_t      box_left,
    output maze_pkg::pixel_t      box_top,
    output maze_pkg::pixel_t      box_right,
    output maze_pkg::pixel_t      box_bottom
);

    import maze_pkg::*;
    import ghost_pkg::*;

    // tile t covers pixels TILE_PX*(t-1) up to TILE_PX*t
    function automatic pixel_t px_lo(tile_coord_t t);
        return pixel_t'(`TILE_PX * (t - tile_coord_t'(1)));
    endfunction

    function automatic pixel_t px_hi(tile_coord_t t);
        return pixel_t'(`TILE_PX * t);
    endfunction

    move_state_e state;
    logic        accept;
    tile_coord_t step_x;
    tile_coord_t step_y;

    // only idle takes a request, so one move is in flight at most
    assign move_ready = (state == st_idle);
    assign accept     = move_valid && move_ready;

    // one tile along the chosen heading
    always_comb begin
        step_x = ghost_x;
        step_y = ghost_y;
        case (next_heading)
            head_left:  step_x = ghost_x - tile_coord_t'(1);
            head_right: step_x = ghost_x + tile_coord_t'(1);
            head_up:    step_y = ghost_y - tile_coord_t'(1);
            head_down:  step_y = ghost_y + tile_coord_t'(1);
            default:    ;
        endcase
    end

    ////////////////////
    // sequencer and position
    ////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= st_idle;
            pos_valid  <= 1'b0;
            ghost_x    <= tile_coord_t'(`START_X);
            ghost_y    <= tile_coord_t'(`START_Y);
            heading    <= head_right;
            box_left   <= px_lo(tile_coord_t'(`START_X));
            box_right  <= px_hi(tile_coord_t'(`START_X));
            box_top    <= px_lo(tile_coord_t'(`START_Y));
            box_bottom <= px_hi(tile_coord_t'(`START_Y));
        end else begin
            // strobe lasts a single cycle
            pos_valid <= 1'b0;
            case (state)
                st_idle: begin
                    if (accept) begin
                        state <= st_step;
                    end
                end
                st_step: begin
                    state      <= st_idle;
                    pos_valid  <= 1'b1;
                    ghost_x    <= step_x;
                    ghost_y    <= step_y;
                    box_left   <= px_lo(step_x);
                    box_right  <= px_hi(step_x);
                    box_top    <= px_lo(step_y);
                    box_bottom <= px_hi(step_y);
                    // a blocked step leaves the old heading in place
                    if (next_heading != head_none) begin
                        heading <= next_heading;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // player tile held for the arbiter during the step
    always_ff @(posedge clk) begin
        if (accept) begin
            target_x <= pac_x;
            target_y <= pac_y;
        end
    end

endmodule

// ==== chase_arbiter.sv ====
module chase_arbiter (
    input  maze_pkg::tile_coord_t ghost_x,
    input  maze_pkg::tile_coord_t ghost_y,
    input  maze_pkg::tile_coord_t pac_x,
    input  maze_pkg::tile_coord_t pac_y,
    input  maze_pkg::dir_mask_t   open_dirs,
    input  ghost_pkg::heading_e   heading,
    output ghost_pkg::heading_e   next_heading
);

    import maze_pkg::*;
    import ghost_pkg::*;

    ////////////////////
    // relative position
    ////////////////////

    logic pac_left;
    logic pac_right;
    logic pac_up;
    logic pac_down;

    tile_coord_t dist_x;
    tile_coord_t dist_y;

    assign pac_left  = pac_x < ghost_x;
    assign pac_right = pac_x > ghost_x;
    // smaller row index is higher on screen
    assign pac_up    = pac_y < ghost_y;
    assign pac_down  = pac_y > ghost_y;

    // absolute distance per axis, always subtract the smaller side
    assign dist_x = pac_right ? (pac_x - ghost_x) : (ghost_x - pac_x);
    assign dist_y = pac_down ? (pac_y - ghost_y) : (ghost_y - pac_y);

    ////////////////////
    // axis headings
    ////////////////////

    heading_e horiz;
    heading_e vert;
    heading_e primary;
    heading_e secondary;

    // toward the player on each axis
    // an axis already lined up gives no heading
    always_comb begin
        horiz = head_none;
        if (pac_right) begin
            horiz = head_right;
        end else if (pac_left) begin
            horiz = head_left;
        end

        vert = head_none;
        if (pac_down) begin
            vert = head_down;
        end else if (pac_up) begin
            vert = head_up;
        end
    end

    // larger distance wins, a tie goes vertical
    // with the player on our own tile both end up head_none
    always_comb begin
        if (dist_y >= dist_x) begin
            primary   = vert;
            secondary = horiz;
        end else begin
            primary   = horiz;
            secondary = vert;
        end
    end

    ////////////////////
    // pick
    ////////////////////

    // head_none has no bits set so it is never usable
    function automatic logic usable(heading_e h, dir_mask_t mask);
        return |(mask & dir_mask_t'(h));
    endfunction

    // first open choice in preference order
    always_comb begin
        if (usable(primary, open_dirs)) begin
            next_heading = primary;
        end else if (usable(secondary, open_dirs)) begin
            next_heading = secondary;
        end else if (usable(heading, open_dirs)) begin
            // keep going the way we were
            next_heading = heading;
        end else if (usable(head_up, open_dirs)) begin
            next_heading = head_up;
        end else if (usable(head_left, open_dirs)) begin
            next_heading = head_left;
        end else if (usable(head_down, open_dirs)) begin
            next_heading = head_down;
        end else if (usable(head_right, open_dirs)) begin
            next_heading = head_right;
        end else begin
            // boxed in on all sides
            next_heading = head_none;
        end
    end

endmodule

// ==== maze_map.sv ====
`include "ghost_chase_defines.svh"

module maze_map (
    input  maze_pkg::tile_coord_t tile_x,
    input  maze_pkg::tile_coord_t tile_y,
    output maze_pkg::dir_mask_t   open_dirs
);

    import maze_pkg::*;

    ////////////////////
    // wall rule
    ////////////////////

    // border ring is solid
    // coordinates that wrapped below zero land past the far edge and count as wall
    // interior pillars on the PILLAR_STEP lattice
    function automatic logic is_wall(tile_coord_t x, tile_coord_t y);
        logic border;
        logic pillar;
        border = (x == '0) || (y == '0) ||
                 (x >= tile_coord_t'(`MAZE_W - 1)) ||
                 (y >= tile_coord_t'(`MAZE_H - 1));
        // zero is a multiple too but is already covered by the border
        pillar = ((x % tile_coord_t'(`PILLAR_STEP)) == '0) &&
                 ((y % tile_coord_t'(`PILLAR_STEP)) == '0);
        return border || pillar;
    endfunction

    ////////////////////
    // neighbour tiles
    ////////////////////

    tile_coord_t left_x;
    tile_coord_t right_x;
    tile_coord_t up_y;
    tile_coord_t down_y;

    // plain wrap on underflow, the wall rule catches it
    assign left_x  = tile_x - tile_coord_t'(1);
    assign right_x = tile_x + tile_coord_t'(1);
    // screen rows grow downward
    assign up_y    = tile_y - tile_coord_t'(1);
    assign down_y  = tile_y + tile_coord_t'(1);

    ////////////////////
    // open mask
    ////////////////////

    // left
    assign open_dirs[0] = !is_wall(left_x, tile_y);
    // right
    assign open_dirs[1] = !is_wall(right_x, tile_y);
    // up
    assign open_dirs[2] = !is_wall(tile_x, up_y);
    // down
    assign open_dirs[3] = !is_wall(tile_x, down_y);

endmodule

// ==== ghost_pkg.sv ====
package ghost_pkg;

    ////////////////////
    // heading
    ////////////////////

    // one-hot heading, bit positions line up with maze_pkg::dir_mask_t
    // so a heading can be masked directly against the open directions
    typedef enum logic [3:0] {
        head_none  = 4'b0000,
        head_left  = 4'b0001,
        head_right = 4'b0010,
        head_up    = 4'b0100,
        head_down  = 4'b1000
    } heading_e;

    ////////////////////
    // move sequencer
    ////////////////////

    // idle waits for a request
    // step applies the chosen heading for one cycle
    typedef enum logic {
        st_idle = 1'b0,
        st_step = 1'b1
    } move_state_e;

endpackage

// ==== maze_pkg.sv ====
`include "ghost_chase_defines.svh"

package maze_pkg;

    ////////////////////
    // coordinates
    ////////////////////

    // tile column or row index
    typedef logic [`COORD_W-1:0] tile_coord_t;

    // screen pixel coordinate
    // same width as a tile index, the box never exceeds the grid
    typedef logic [`COORD_W-1:0] pixel_t;

    ////////////////////
    // neighbour mask
    ////////////////////

    // one bit per neighbouring tile, set when that tile is open
    // bit 0 left
    // bit 1 right
    // bit 2 up
    // bit 3 down
    typedef logic [3:0] dir_mask_t;

endpackage

// ==== ghost_chase_defines.svh ====
`ifndef GHOST_CHASE_DEFINES_SVH
`define GHOST_CHASE_DEFINES_SVH

////////////////////
// maze geometry
////////////////////

// grid size in tiles, border ring included
`define MAZE_W 16
`define MAZE_H 12

// pixels per tile edge
`define TILE_PX 10

// width of tile and pixel coordinates
`define COORD_W 10

// interior pillars sit where both column and row are multiples of this
`define PILLAR_STEP 3

////////////////////
// ghost start tile
////////////////////
`define START_X 2
`define START_Y 2

`endif
